//--- design/dbg_noc_macros.svh
// Debug NoC constants
// Flit and header field widths, ring addresses, system identifier
// and the TCM register map

`ifndef DBG_NOC_MACROS_SVH
`define DBG_NOC_MACROS_SVH

// Flit layout
`define DBG_FLIT_TYPE_W 2
`define DBG_FLIT_DATA_W 16
`define DBG_FLIT_W (`DBG_FLIT_TYPE_W + `DBG_FLIT_DATA_W)

// Header fields, destination in the upper bits
`define DBG_DEST_W 5
`define DBG_CLASS_W 3
`define DBG_SRC_W 8

// Ring addresses
`define DBG_ADDR_EXTIF `DBG_DEST_W'(0)
`define DBG_ADDR_TCM `DBG_DEST_W'(1)

`define DBG_SYSTEM_ID 16'h0da1

// TCM registers
`define TCM_REG_SYSID 16'd0
`define TCM_REG_CPUCTRL 16'd1
`define TCM_REG_START 16'd2
`define TCM_REG_STATUS 16'd3
`define TCM_REG_TIMESTAMP 16'd4

`endif

//--- design/dbg_noc_pkg.sv
// Debug NoC types
// Flit type and packet class encodings, and the flit layout whose content
// reads as a header or as a plain data word

`include "dbg_noc_macros.svh"

package dbg_noc_pkg;

   typedef enum logic [`DBG_FLIT_TYPE_W-1:0] {
      PAYLOAD = 0,
      HEADER  = 1,
      LAST    = 2,
      SINGLE  = 3
   } dbg_flit_type_e;

   typedef enum logic [`DBG_CLASS_W-1:0] {
      REG_READ      = 0,
      REG_WRITE     = 1,
      REG_READ_RESP = 2
   } dbg_class_e;

   typedef logic [`DBG_DEST_W-1:0] dbg_dest_t;

   typedef struct packed {
      dbg_dest_t              dest;
      dbg_class_e             pclass;
      logic [`DBG_SRC_W-1:0]  src;
   } dbg_header_t;

   typedef union packed {
      dbg_header_t                 hdr;
      logic [`DBG_FLIT_DATA_W-1:0] data;
   } dbg_content_u;

   typedef struct packed {
      dbg_flit_type_e ftype;
      dbg_content_u   content;
   } dbg_flit_t;

   function automatic logic dbg_is_head(dbg_flit_type_e ftype);
      return (ftype == HEADER) || (ftype == SINGLE);
   endfunction

   function automatic logic dbg_is_tail(dbg_flit_type_e ftype);
      return (ftype == LAST) || (ftype == SINGLE);
   endfunction

endpackage

//--- design/dbg_ring_router.sv
// Debug ring router
// Ejects packets addressed to this node to the local port, forwards the rest
// and merges locally injected packets into the ring between packets

`timescale 1ns/10ps

module dbg_ring_router import dbg_noc_pkg::*; #(
   parameter dbg_dest_t ROUTER_ADDR = '0
) (
   input  logic      clk,
   input  logic      rst_n_i,
   input  dbg_flit_t ring_in_flit_i,
   input  logic      ring_in_valid_i,
   output logic      ring_in_ready_o,
   output dbg_flit_t ring_out_flit_o,
   output logic      ring_out_valid_o,
   input  logic      ring_out_ready_i,
   input  dbg_flit_t local_in_flit_i,
   input  logic      local_in_valid_i,
   output logic      local_in_ready_o,
   output dbg_flit_t local_out_flit_o,
   output logic      local_out_valid_o,
   input  logic      local_out_ready_i
);

   typedef enum logic [1:0] {OWN_NONE, OWN_RING, OWN_LOCAL} owner_e;

   owner_e    owner_q;
   logic      eject_q;
   logic      eject;
   logic      ring_fwd_req;
   logic      sel_ring;
   logic      sel_local;
   logic      ring_can_load;
   logic      local_can_load;
   logic      eject_xfer;
   logic      fwd_xfer;
   logic      inject_xfer;
   dbg_flit_t ring_out_d;

   // Route chosen by the header, body flits follow it
   assign eject = dbg_is_head(ring_in_flit_i.ftype) ?
                  (ring_in_flit_i.content.hdr.dest == ROUTER_ADDR) : eject_q;
   assign ring_fwd_req = ring_in_valid_i && !eject;

   // Ring output reloads only when empty, keeps ready from looping round the ring
   assign ring_can_load  = !ring_out_valid_o;
   assign local_can_load = !local_out_valid_o || local_out_ready_i;

   // Output owner changes only between packets, ring traffic first
   assign sel_ring  = (owner_q == OWN_RING) || (owner_q == OWN_NONE && ring_fwd_req);
   assign sel_local = (owner_q == OWN_LOCAL) ||
                      (owner_q == OWN_NONE && !ring_fwd_req && local_in_valid_i);

   assign ring_in_ready_o  = eject ? local_can_load : (sel_ring && ring_can_load);
   assign local_in_ready_o = sel_local && ring_can_load;

   assign eject_xfer  = ring_in_valid_i && eject && local_can_load;
   assign fwd_xfer    = ring_fwd_req && sel_ring && ring_can_load;
   assign inject_xfer = local_in_valid_i && sel_local && ring_can_load;
   assign ring_out_d  = sel_ring ? ring_in_flit_i : local_in_flit_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         owner_q           <= OWN_NONE;
         eject_q           <= 1'b0;
         ring_out_valid_o  <= 1'b0;
         local_out_valid_o <= 1'b0;
      end else begin
         if (ring_in_valid_i && ring_in_ready_o) begin
            eject_q <= eject;
         end
         if (fwd_xfer || inject_xfer) begin
            ring_out_valid_o <= 1'b1;
            if (dbg_is_tail(ring_out_d.ftype)) begin
               owner_q <= OWN_NONE;
            end else begin
               owner_q <= fwd_xfer ? OWN_RING : OWN_LOCAL;
            end
         end else if (ring_out_ready_i) begin
            ring_out_valid_o <= 1'b0;
         end
         if (eject_xfer) begin
            local_out_valid_o <= 1'b1;
         end else if (local_out_ready_i) begin
            local_out_valid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fwd_xfer || inject_xfer) begin
         ring_out_flit_o <= ring_out_d;
      end
      if (eject_xfer) begin
         local_out_flit_o <= ring_in_flit_i;
      end
   end

   a_ring_out_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      ring_out_valid_o && !ring_out_ready_i |=> ring_out_valid_o && $stable(ring_out_flit_o))
      else $error("ring output flit changed while stalled");

   a_local_out_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      local_out_valid_o && !local_out_ready_i |=> local_out_valid_o && $stable(local_out_flit_o))
      else $error("local output flit changed while stalled");

   // Once a packet owns the ring output, no new header may start
   a_no_nested_header: assert property (@(posedge clk) disable iff (!rst_n_i)
      (fwd_xfer || inject_xfer) && owner_q != OWN_NONE |-> !dbg_is_head(ring_out_d.ftype))
      else $error("header flit inside a packet on the ring output");

endmodule

//--- design/dbg_tcm.sv
// Trace control module
// Decodes register read and write packets, holds the CPU control bits and
// the global timestamp, and answers reads with a two-flit response

`timescale 1ns/10ps
`include "dbg_noc_macros.svh"

module dbg_tcm import dbg_noc_pkg::*; (
   input  logic      clk,
   input  logic      rst_n_i,
   input  logic      sys_clk_is_halted_i,
   input  dbg_flit_t req_flit_i,
   input  logic      req_valid_i,
   output logic      req_ready_o,
   output dbg_flit_t resp_flit_o,
   output logic      resp_valid_o,
   input  logic      resp_ready_i,
   output logic      cpu_stall_o,
   output logic      cpu_reset_o,
   output logic      start_cpu_o
);

   typedef enum logic [2:0] {
      ST_HDR,
      ST_ADDR,
      ST_DATA,
      ST_DROP,
      ST_RESP_HDR,
      ST_RESP_DATA
   } state_e;

   state_e                      state_q;
   logic                        is_write_q;
   dbg_dest_t                   src_q;
   logic [`DBG_FLIT_DATA_W-1:0] addr_q;
   logic [`DBG_FLIT_DATA_W-1:0] rdata_q;
   logic [`DBG_FLIT_DATA_W-1:0] rdata;
   logic [`DBG_FLIT_DATA_W-1:0] req_data;
   logic [`DBG_FLIT_DATA_W-1:0] timestamp_q;
   logic                        req_xfer;
   dbg_class_e                  req_class;

   assign req_data     = req_flit_i.content.data;
   assign req_class    = req_flit_i.content.hdr.pclass;
   assign resp_valid_o = (state_q == ST_RESP_HDR) || (state_q == ST_RESP_DATA);
   // No new request while a response is pending
   assign req_ready_o  = !resp_valid_o;
   assign req_xfer     = req_valid_i && req_ready_o;

   // Register read mux, addressed by the incoming address flit
   always_comb begin
      case (req_data)
         `TCM_REG_SYSID:     rdata = `DBG_SYSTEM_ID;
         `TCM_REG_CPUCTRL:   rdata = {{(`DBG_FLIT_DATA_W-2){1'b0}}, cpu_reset_o, cpu_stall_o};
         `TCM_REG_STATUS:    rdata = {{(`DBG_FLIT_DATA_W-1){1'b0}}, sys_clk_is_halted_i};
         `TCM_REG_TIMESTAMP: rdata = timestamp_q;
         default:            rdata = '0;
      endcase
   end

   // Response goes back to the requester
   always_comb begin
      resp_flit_o = '0;
      if (state_q == ST_RESP_HDR) begin
         resp_flit_o.ftype              = HEADER;
         resp_flit_o.content.hdr.dest   = src_q;
         resp_flit_o.content.hdr.pclass = REG_READ_RESP;
         resp_flit_o.content.hdr.src    = `DBG_SRC_W'(`DBG_ADDR_TCM);
      end else begin
         resp_flit_o.ftype        = LAST;
         resp_flit_o.content.data = rdata_q;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= ST_HDR;
         is_write_q  <= 1'b0;
         cpu_stall_o <= 1'b0;
         cpu_reset_o <= 1'b0;
         start_cpu_o <= 1'b0;
         timestamp_q <= '0;
      end else begin
         timestamp_q <= timestamp_q + 1'b1;
         start_cpu_o <= 1'b0;
         case (state_q)
            ST_HDR: begin
               if (req_xfer && req_flit_i.ftype == HEADER) begin
                  is_write_q <= (req_class == REG_WRITE);
                  if (req_class == REG_READ || req_class == REG_WRITE) begin
                     state_q <= ST_ADDR;
                  end else begin
                     state_q <= ST_DROP;
                  end
               end
            end
            ST_ADDR: begin
               if (req_xfer) begin
                  if (is_write_q) begin
                     state_q <= (req_flit_i.ftype == PAYLOAD) ? ST_DATA : ST_HDR;
                  end else begin
                     state_q <= dbg_is_tail(req_flit_i.ftype) ? ST_RESP_HDR : ST_DROP;
                  end
               end
            end
            ST_DATA: begin
               if (req_xfer) begin
                  if (dbg_is_tail(req_flit_i.ftype)) begin
                     state_q <= ST_HDR;
                     if (addr_q == `TCM_REG_CPUCTRL) begin
                        cpu_stall_o <= req_data[0];
                        cpu_reset_o <= req_data[1];
                     end
                     if (addr_q == `TCM_REG_START) begin
                        start_cpu_o <= 1'b1;
                     end
                  end else begin
                     // Overlong write, skip the rest
                     state_q <= ST_DROP;
                  end
               end
            end
            ST_DROP: begin
               if (req_xfer && dbg_is_tail(req_flit_i.ftype)) begin
                  state_q <= ST_HDR;
               end
            end
            ST_RESP_HDR: begin
               if (resp_ready_i) begin
                  state_q <= ST_RESP_DATA;
               end
            end
            default: begin
               if (resp_ready_i) begin
                  state_q <= ST_HDR;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (req_xfer && state_q == ST_HDR) begin
         src_q <= req_flit_i.content.hdr.src[`DBG_DEST_W-1:0];
      end
      // Read data sampled with the address
      if (req_xfer && state_q == ST_ADDR) begin
         addr_q  <= req_data;
         rdata_q <= rdata;
      end
   end

   a_start_single_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
      start_cpu_o |=> !start_cpu_o)
      else $error("start_cpu_o held high for more than one cycle");

endmodule

//--- design/debug_system.sv
// Debug system top level
// Two routers form a unidirectional ring, router 0 serves the external
// debug port and router 1 serves the trace control module

`timescale 1ns/10ps
`include "dbg_noc_macros.svh"

module debug_system import dbg_noc_pkg::*; (
   input  logic      clk,
   input  logic      rst_n_i,
   input  logic      sys_clk_is_halted_i,
   input  dbg_flit_t dbgnoc_in_flit_i,
   input  logic      dbgnoc_in_valid_i,
   output logic      dbgnoc_in_ready_o,
   output dbg_flit_t dbgnoc_out_flit_o,
   output logic      dbgnoc_out_valid_o,
   input  logic      dbgnoc_out_ready_i,
   output logic      cpu_stall_o,
   output logic      cpu_reset_o,
   output logic      start_cpu_o
);

   // Ring links
   dbg_flit_t ring_01_flit;
   logic      ring_01_valid;
   logic      ring_01_ready;
   dbg_flit_t ring_10_flit;
   logic      ring_10_valid;
   logic      ring_10_ready;

   // TCM attachment
   dbg_flit_t tcm_req_flit;
   logic      tcm_req_valid;
   logic      tcm_req_ready;
   dbg_flit_t tcm_resp_flit;
   logic      tcm_resp_valid;
   logic      tcm_resp_ready;

   dbg_ring_router #(
      .ROUTER_ADDR(`DBG_ADDR_EXTIF)
   ) u_router_extif (
      .clk               (clk),
      .rst_n_i           (rst_n_i),
      .ring_in_flit_i    (ring_10_flit),
      .ring_in_valid_i   (ring_10_valid),
      .ring_in_ready_o   (ring_10_ready),
      .ring_out_flit_o   (ring_01_flit),
      .ring_out_valid_o  (ring_01_valid),
      .ring_out_ready_i  (ring_01_ready),
      .local_in_flit_i   (dbgnoc_in_flit_i),
      .local_in_valid_i  (dbgnoc_in_valid_i),
      .local_in_ready_o  (dbgnoc_in_ready_o),
      .local_out_flit_o  (dbgnoc_out_flit_o),
      .local_out_valid_o (dbgnoc_out_valid_o),
      .local_out_ready_i (dbgnoc_out_ready_i)
   );

   dbg_ring_router #(
      .ROUTER_ADDR(`DBG_ADDR_TCM)
   ) u_router_tcm (
      .clk               (clk),
      .rst_n_i           (rst_n_i),
      .ring_in_flit_i    (ring_01_flit),
      .ring_in_valid_i   (ring_01_valid),
      .ring_in_ready_o   (ring_01_ready),
      .ring_out_flit_o   (ring_10_flit),
      .ring_out_valid_o  (ring_10_valid),
      .ring_out_ready_i  (ring_10_ready),
      .local_in_flit_i   (tcm_resp_flit),
      .local_in_valid_i  (tcm_resp_valid),
      .local_in_ready_o  (tcm_resp_ready),
      .local_out_flit_o  (tcm_req_flit),
      .local_out_valid_o (tcm_req_valid),
      .local_out_ready_i (tcm_req_ready)
   );

   dbg_tcm u_tcm (
      .clk                 (clk),
      .rst_n_i             (rst_n_i),
      .sys_clk_is_halted_i (sys_clk_is_halted_i),
      .req_flit_i          (tcm_req_flit),
      .req_valid_i         (tcm_req_valid),
      .req_ready_o         (tcm_req_ready),
      .resp_flit_o         (tcm_resp_flit),
      .resp_valid_o        (tcm_resp_valid),
      .resp_ready_i        (tcm_resp_ready),
      .cpu_stall_o         (cpu_stall_o),
      .cpu_reset_o         (cpu_reset_o),
      .start_cpu_o         (start_cpu_o)
   );

endmodule

//--- verif/tb_clk_gen.sv
// Testbench clock and reset generator
// 20 ns clock, active low reset held for the first 16 cycles

`timescale 1ns/10ps

module tb_clk_gen #(
   parameter int RESET_CYCLES = 16
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b1;
      // Clean falling edge once every reset input is listening
      #1;
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      // Release on a falling edge, away from the sampling edge
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

//--- verif/tb_debug_system.sv
// Debug system testbench
// Register reads and writes through the ring to the TCM, the CPU control
// outputs, and throttled loopback packets on the external debug port

`timescale 1ns/10ps
`include "dbg_noc_macros.svh"

module tb_debug_system import dbg_noc_pkg::*; ();

   // Tests need roughly 3000 cycles
   localparam int MAX_CYCLES = 20000;
   localparam int LB_PACKETS = 20;

   logic      clk;
   logic      rst_n;
   logic      sys_clk_is_halted;
   dbg_flit_t in_flit;
   logic      in_valid;
   logic      in_ready;
   dbg_flit_t out_flit;
   logic      out_valid;
   logic      out_ready;
   logic      cpu_stall;
   logic      cpu_reset;
   logic      start_cpu;

   int        seed;
   int        cycle_count = 0;
   int        start_count = 0;
   logic      req_started;
   logic      throttle_en;
   dbg_flit_t out_q[$];
   dbg_flit_t lb_flits[$];
   int        lb_pkt_len[$];

   tb_clk_gen u_clk_gen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   debug_system i_dut (
      .clk                 (clk),
      .rst_n_i             (rst_n),
      .sys_clk_is_halted_i (sys_clk_is_halted),
      .dbgnoc_in_flit_i    (in_flit),
      .dbgnoc_in_valid_i   (in_valid),
      .dbgnoc_in_ready_o   (in_ready),
      .dbgnoc_out_flit_o   (out_flit),
      .dbgnoc_out_valid_o  (out_valid),
      .dbgnoc_out_ready_i  (out_ready),
      .cpu_stall_o         (cpu_stall),
      .cpu_reset_o         (cpu_reset),
      .start_cpu_o         (start_cpu)
   );

   task automatic report_mismatch(input string msg);
      $display("TB FAILED");
      $display("Mismatch at %0d ns: %s", $time, msg);
      $fatal(1, "Stopping at the first error");
   endtask

   task automatic report_failure(input string msg);
      $display("TB FAILED");
      $display("%s", msg);
      $fatal(1, "Stopping the run");
   endtask

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      assert (actual == expected)
         else report_mismatch($sformatf("%s: got 0x%0h, expected 0x%0h",
                                        what, actual, expected));
   endtask

   function automatic dbg_flit_t make_flit(input dbg_flit_type_e ftype,
                                            input logic [15:0] data);
      dbg_flit_t f;
      f.ftype        = ftype;
      f.content.data = data;
      return f;
   endfunction

   function automatic dbg_flit_t make_header(input dbg_dest_t dest, input dbg_class_e pclass,
                                              input logic [7:0] src);
      dbg_flit_t f;
      f.ftype              = HEADER;
      f.content.hdr.dest   = dest;
      f.content.hdr.pclass = pclass;
      f.content.hdr.src    = src;
      return f;
   endfunction

   // One flit per accepted cycle, valid held until ready
   task automatic send_packet(input dbg_flit_t pkt[$]);
      int i;
      for (i = 0; i < pkt.size(); i++) begin
         @(negedge clk);
         req_started = 1'b1;
         in_flit     = pkt[i];
         in_valid    = 1'b1;
         @(posedge clk);
         while (!in_ready) @(posedge clk);
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic wait_flits(input int n);
      while (out_q.size() < n) @(negedge clk);
   endtask

   task automatic check_queue_empty(input string where);
      assert (out_q.size() == 0)
         else report_mismatch($sformatf("%0d unexpected flits on the debug output %s",
                                        out_q.size(), where));
   endtask

   task automatic read_reg(input logic [15:0] addr, output logic [15:0] data);
      dbg_flit_t pkt[$];
      dbg_flit_t rsp_hdr;
      dbg_flit_t rsp_data;
      check_queue_empty("before a read");
      pkt.push_back(make_header(`DBG_ADDR_TCM, REG_READ, 8'(`DBG_ADDR_EXTIF)));
      pkt.push_back(make_flit(LAST, addr));
      send_packet(pkt);
      wait_flits(2);
      rsp_hdr  = out_q.pop_front();
      rsp_data = out_q.pop_front();
      check_equal(rsp_hdr.ftype, HEADER, "response header type");
      check_equal(rsp_hdr.content.hdr.dest, `DBG_ADDR_EXTIF, "response destination");
      check_equal(rsp_hdr.content.hdr.pclass, REG_READ_RESP, "response class");
      check_equal(rsp_hdr.content.hdr.src, 8'(`DBG_ADDR_TCM), "response source");
      check_equal(rsp_data.ftype, LAST, "response data flit type");
      data = rsp_data.content.data;
   endtask

   task automatic write_reg(input logic [15:0] addr, input logic [15:0] data);
      dbg_flit_t pkt[$];
      pkt.push_back(make_header(`DBG_ADDR_TCM, REG_WRITE, 8'(`DBG_ADDR_EXTIF)));
      pkt.push_back(make_flit(PAYLOAD, addr));
      pkt.push_back(make_flit(LAST, data));
      send_packet(pkt);
   endtask

   // Loopback packets to address 0 with 0 to 5 payload flits
   task automatic build_loopback();
      int p;
      int k;
      int nbody;
      for (p = 0; p < LB_PACKETS; p++) begin
         nbody = $unsigned($random(seed)) % 6;
         lb_flits.push_back(make_header(`DBG_ADDR_EXTIF, REG_WRITE, 8'(p)));
         for (k = 0; k < nbody; k++) begin
            lb_flits.push_back(make_flit(PAYLOAD, 16'($random(seed))));
         end
         lb_flits.push_back(make_flit(LAST, 16'($random(seed))));
         lb_pkt_len.push_back(nbody + 2);
      end
   endtask

   task automatic check_loopback();
      dbg_flit_t pkt[$];
      dbg_flit_t got;
      int        idx;
      int        p;
      int        k;
      idx = 0;
      for (p = 0; p < LB_PACKETS; p++) begin
         pkt = {};
         for (k = 0; k < lb_pkt_len[p]; k++) begin
            pkt.push_back(lb_flits[idx]);
            idx++;
         end
         send_packet(pkt);
      end
      wait_flits(lb_flits.size());
      for (k = 0; k < lb_flits.size(); k++) begin
         got = out_q.pop_front();
         check_equal(got, lb_flits[k], $sformatf("loopback flit %0d", k));
      end
   endtask

   // Output ready, random once throttling is on
   initial begin
      int rnd;
      out_ready = 1'b1;
      forever begin
         @(negedge clk);
         if (throttle_en) begin
            rnd       = $random(seed);
            out_ready = (rnd[1:0] != 2'b00);
         end else begin
            out_ready = 1'b1;
         end
      end
   end

   always @(posedge clk) begin
      if (rst_n && out_valid && out_ready) begin
         out_q.push_back(out_flit);
      end
      if (rst_n && start_cpu) begin
         start_count <= start_count + 1;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         report_failure($sformatf("Run did not finish within %0d clock cycles", MAX_CYCLES));
      end
   end

   a_idle_until_request: assert property (@(posedge clk)
      !req_started |-> !out_valid && !cpu_stall && !cpu_reset && !start_cpu)
      else report_mismatch("output active before the first request");

   a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_flit))
      else report_mismatch("debug output flit changed while stalled");

   a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      start_cpu |=> !start_cpu)
      else report_mismatch("start_cpu_o high for more than one cycle");

   initial begin
      logic [15:0] rdata;
      logic [15:0] ts_first;
      int          starts_before;
      int          i;
      int          v;
      seed              = 42;
      in_flit           = '0;
      in_valid          = 1'b0;
      sys_clk_is_halted = 1'b0;
      req_started       = 1'b0;
      throttle_en       = 1'b0;
      build_loopback();
      wait (rst_n === 1'b1);
      repeat (20) @(negedge clk);
      throttle_en = 1'b1;

      read_reg(`TCM_REG_SYSID, rdata);
      check_equal(rdata, `DBG_SYSTEM_ID, "system identifier");
      read_reg(16'h0005, rdata);
      check_equal(rdata, 16'h0000, "unused register 5");
      read_reg(16'h00ff, rdata);
      check_equal(rdata, 16'h0000, "unused register 0xff");

      starts_before = start_count;
      for (i = 0; i < 4; i++) begin
         v = (i + 1) % 4;
         write_reg(`TCM_REG_CPUCTRL, 16'(v));
         // Readback also makes sure the write has reached the TCM
         read_reg(`TCM_REG_CPUCTRL, rdata);
         check_equal(rdata, v, "CPU control readback");
         check_equal(cpu_stall, v[0], "cpu_stall_o");
         check_equal(cpu_reset, v[1], "cpu_reset_o");
      end
      check_equal(start_count, starts_before, "start pulses after CPU control writes");

      write_reg(`TCM_REG_START, 16'h0001);
      read_reg(`TCM_REG_SYSID, rdata);
      check_equal(start_count, starts_before + 1, "start_cpu_o high cycles");

      @(negedge clk);
      sys_clk_is_halted = 1'b1;
      read_reg(`TCM_REG_STATUS, rdata);
      check_equal(rdata, 16'h0001, "status with clock halted");
      @(negedge clk);
      sys_clk_is_halted = 1'b0;
      read_reg(`TCM_REG_STATUS, rdata);
      check_equal(rdata, 16'h0000, "status with clock running");

      read_reg(`TCM_REG_TIMESTAMP, ts_first);
      read_reg(`TCM_REG_TIMESTAMP, rdata);
      assert (rdata > ts_first)
         else report_mismatch($sformatf("timestamp went from 0x%0h to 0x%0h",
                                        ts_first, rdata));

      check_loopback();
      repeat (50) @(negedge clk);
      check_queue_empty("at the end of the run");
      $display("TB PASSED");
      $finish;
   end

endmodule

//--- sources.f
+incdir+design
design/dbg_noc_pkg.sv
design/dbg_ring_router.sv
design/dbg_tcm.sv
design/debug_system.sv
verif/tb_clk_gen.sv
verif/tb_debug_system.sv

//--- Bender.yml
package:
  name: debug_system

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/dbg_noc_pkg.sv
      - design/dbg_ring_router.sv
      - design/dbg_tcm.sv
      - design/debug_system.sv
      - target: test
        files:
          - verif/tb_clk_gen.sv
          - verif/tb_debug_system.sv
